//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;    // 8086 register order
    typedef logic [11:0] flags_t;      // ODITSZ-A-P-C layout
    typedef logic [2:0]  alu_op_t;     // Opcode bits 5..3

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_MODRM,
        ST_EXEC,
        ST_HALT
    } cpu_state_t;

    // Register numbers
    localparam reg_idx_t REG_AX = 3'd0;
    localparam reg_idx_t REG_CX = 3'd1;
    localparam reg_idx_t REG_DX = 3'd2;
    localparam reg_idx_t REG_BX = 3'd3;

    // --------------------------------------------------
    // Flag bit positions
    // --------------------------------------------------
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_AF = 4;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_OF = 11;

    // ALU codes as in opcode bits 5..3
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_OR  = 3'd1;
    localparam alu_op_t ALU_ADC = 3'd2;
    localparam alu_op_t ALU_SBB = 3'd3;
    localparam alu_op_t ALU_AND = 3'd4;
    localparam alu_op_t ALU_SUB = 3'd5;
    localparam alu_op_t ALU_XOR = 3'd6;
    localparam alu_op_t ALU_CMP = 3'd7;

    // Carry commands for CLC, STC and CMC
    localparam logic [1:0] CARRY_CLR = 2'd0;
    localparam logic [1:0] CARRY_SET = 2'd1;
    localparam logic [1:0] CARRY_CMC = 2'd2;

    localparam addr_t RESET_IP = 16'h0000;

endpackage

//--- rtl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_pkg::alu_op_t    i_op,
    input  logic                i_size,
    input  cpu_pkg::word_t      i_a,
    input  cpu_pkg::word_t      i_b,
    input  cpu_pkg::flags_t     i_flags,
    output cpu_pkg::word_t      o_result,
    output cpu_pkg::flags_t     o_flags
);
    import cpu_pkg::*;

    logic [16:0] a, b, r;       // Carry lands in bit 8 or bit 16
    logic [4:0]  top;           // Sign bit position
    logic        cin;

    assign a        = i_size ? {1'b0, i_a} : {9'h000, i_a[7:0]};
    assign b        = i_size ? {1'b0, i_b} : {9'h000, i_b[7:0]};
    assign top      = i_size ? 5'd15 : 5'd7;
    assign cin      = i_flags[FLAG_CF];
    assign o_result = r[15:0];

    always_comb begin
        case (i_op)
            ALU_ADD: r = a + b;
            ALU_OR:  r = a | b;
            ALU_ADC: r = a + b + {16'h0000, cin};
            ALU_SBB: r = a - b - {16'h0000, cin};
            ALU_AND: r = a & b;
            ALU_XOR: r = a ^ b;
            default: r = a - b;                 // SUB and CMP
        endcase
    end

    // --------------------------------------------------
    // Flags
    // --------------------------------------------------
    always_comb begin
        o_flags          = i_flags;
        o_flags[FLAG_CF] = r[top + 5'd1];
        o_flags[FLAG_AF] = a[4] ^ b[4] ^ r[4];
        case (i_op)
            ALU_ADD, ALU_ADC:
                o_flags[FLAG_OF] = ~(a[top] ^ b[top]) & (a[top] ^ r[top]);
            ALU_SUB, ALU_SBB, ALU_CMP:
                o_flags[FLAG_OF] = (a[top] ^ b[top]) & (a[top] ^ r[top]);
            default: begin                      // Logical ops
                o_flags[FLAG_OF] = 1'b0;
                o_flags[FLAG_CF] = 1'b0;
                o_flags[FLAG_AF] = r[4];
            end
        endcase
        o_flags[FLAG_SF] = r[top];
        o_flags[FLAG_ZF] = i_size ? (r[15:0] == 16'h0000) : (r[7:0] == 8'h00);
        o_flags[FLAG_PF] = ~^r[7:0];            // Even parity of low byte
    end

endmodule

//--- rtl/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                clock,
    input  logic                i_rst,
    input  logic                i_we,
    input  logic                i_size,         // 1 = word, 0 = byte half
    input  cpu_pkg::reg_idx_t   i_wr_reg,
    input  cpu_pkg::word_t      i_wr_data,
    input  cpu_pkg::reg_idx_t   i_rd_a_reg,
    output cpu_pkg::word_t      o_rd_a,
    input  cpu_pkg::reg_idx_t   i_rd_b_reg,
    output cpu_pkg::word_t      o_rd_b
);
    import cpu_pkg::*;

    word_t regs [8];

    // Byte mode maps 0..3 to AL..BL and 4..7 to AH..BH
    function automatic word_t read_reg(input reg_idx_t idx);
        if (i_size)
            return regs[idx];
        return {8'h00, idx[2] ? regs[idx[1:0]][15:8] : regs[idx[1:0]][7:0]};
    endfunction

    always_comb begin
        o_rd_a = read_reg(i_rd_a_reg);
        o_rd_b = read_reg(i_rd_b_reg);
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (i_we) begin
            if (i_size)
                regs[i_wr_reg] <= i_wr_data;
            else if (i_wr_reg[2])
                regs[i_wr_reg[1:0]][15:8] <= i_wr_data[7:0];   // High half
            else
                regs[i_wr_reg[1:0]][7:0] <= i_wr_data[7:0];
        end
    end

endmodule

//--- rtl/cpu_flags.sv
`timescale 1ns/1ps

module cpu_flags (
    input  logic                clock,
    input  logic                i_rst,
    input  logic                i_we,
    input  cpu_pkg::flags_t     i_new_flags,
    input  logic                i_carry_cmd_en,
    input  logic [1:0]          i_carry_cmd,
    input  logic [3:0]          i_cond,         // Low nibble of the Jcc opcode
    output cpu_pkg::flags_t     o_flags,
    output logic                o_cond_true
);
    import cpu_pkg::*;

    logic [7:0] base;
    logic       sf_ne_of;

    assign sf_ne_of = o_flags[FLAG_SF] ^ o_flags[FLAG_OF];

    // Base conditions, odd codes take the inverse
    assign base = {sf_ne_of | o_flags[FLAG_ZF], sf_ne_of,
                   o_flags[FLAG_PF], o_flags[FLAG_SF],
                   o_flags[FLAG_CF] | o_flags[FLAG_ZF], o_flags[FLAG_ZF],
                   o_flags[FLAG_CF], o_flags[FLAG_OF]};

    assign o_cond_true = base[i_cond[3:1]] ^ i_cond[0];

    always_ff @(posedge clock) begin
        if (i_rst) begin
            o_flags <= '0;
        end else if (i_we) begin
            o_flags <= i_new_flags;
        end else if (i_carry_cmd_en) begin
            case (i_carry_cmd)
                CARRY_CLR: o_flags[FLAG_CF] <= 1'b0;
                CARRY_SET: o_flags[FLAG_CF] <= 1'b1;
                default:   o_flags[FLAG_CF] <= ~o_flags[FLAG_CF];   // CMC
            endcase
        end
    end

endmodule

//--- rtl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                clock,
    input  logic                i_rst,
    input  cpu_pkg::byte_t      i_data,
    output cpu_pkg::addr_t      o_address,
    output cpu_pkg::byte_t      o_data,
    output logic                o_we,
    output logic                o_halt,
    output logic                o_rf_we,
    output logic                o_rf_size,
    output cpu_pkg::reg_idx_t   o_rf_wr_reg,
    output cpu_pkg::word_t      o_rf_wr_data,
    output cpu_pkg::reg_idx_t   o_rf_rd_a,
    output cpu_pkg::reg_idx_t   o_rf_rd_b,
    input  cpu_pkg::word_t      i_rf_a,
    input  cpu_pkg::word_t      i_rf_b,
    output cpu_pkg::alu_op_t    o_alu_op,
    output logic                o_alu_size,
    output cpu_pkg::word_t      o_alu_a,
    output cpu_pkg::word_t      o_alu_b,
    input  cpu_pkg::word_t      i_alu_result,
    input  cpu_pkg::flags_t     i_alu_flags,
    output logic                o_flags_we,
    output cpu_pkg::flags_t     o_flags_new,
    output logic                o_carry_cmd_en,
    output logic [1:0]          o_carry_cmd,
    output logic [3:0]          o_cond,
    input  logic                i_cond_true
);
    import cpu_pkg::*;

    cpu_state_t state;
    addr_t      ip;
    byte_t      opcode, modrm;
    logic       size_bit, dir_bit;
    word_t      op_latch;          // Low byte of immediates, XCHG operand, saved CF
    word_t      ea_imm;            // Absolute address of A0..A3
    logic [1:0] step;
    logic       done;              // Last EXEC cycle of the instruction
    reg_idx_t   dst_reg, src_reg;
    word_t      imm_word, disp;

    assign dst_reg  = dir_bit ? modrm[5:3] : modrm[2:0];
    assign src_reg  = dir_bit ? modrm[2:0] : modrm[5:3];
    assign imm_word = step[0] ? {i_data, op_latch[7:0]} : {8'h00, i_data};
    assign disp     = {{8{i_data[7]}}, i_data};

    // Data phase of A0..A3 runs from the latched address
    assign o_address = (state == ST_EXEC && opcode[7:2] == 6'b101000 && step[1]) ? ea_imm : ip;
    assign o_halt    = (state == ST_HALT);
    assign o_cond    = opcode[3:0];

    // --------------------------------------------------
    // Datapath steering
    // --------------------------------------------------
    always_comb begin
        o_rf_we        = 1'b0;
        o_rf_size      = size_bit;
        o_rf_rd_a      = dst_reg;
        o_rf_rd_b      = src_reg;
        o_rf_wr_reg    = dst_reg;
        o_rf_wr_data   = i_alu_result;
        o_alu_op       = ALU_ADC;      // ADC 0+0 outside EXEC yields the CF
        o_alu_size     = 1'b1;
        o_alu_a        = '0;
        o_alu_b        = '0;
        o_flags_we     = 1'b0;
        o_flags_new    = i_alu_flags;
        o_carry_cmd_en = 1'b0;
        o_carry_cmd    = CARRY_CMC;
        done           = 1'b1;
        if (state == ST_EXEC) begin
            casez (opcode)
                8'b00???0??, 8'b1000010?: begin      // ALU rm,r and TEST rm,r
                    o_alu_op   = opcode[7] ? ALU_AND : opcode[5:3];
                    o_alu_size = size_bit;
                    o_alu_a    = i_rf_a;
                    o_alu_b    = i_rf_b;
                    o_rf_we    = !opcode[7] && opcode[5:3] != ALU_CMP;
                    o_flags_we = 1'b1;
                end
                8'b1000011?: begin                    // XCHG r,rm over two cycles
                    o_rf_we = 1'b1;
                    done    = step[0];
                    if (step[0]) begin
                        o_rf_wr_reg  = modrm[2:0];
                        o_rf_wr_data = op_latch;
                    end else begin
                        o_rf_wr_data = i_rf_b;
                    end
                end
                8'b100010??: begin                    // MOV
                    o_rf_we      = 1'b1;
                    o_rf_wr_data = i_rf_b;
                end
                8'b00???10?, 8'b1010100?: begin      // Accumulator with immediate
                    done        = (step[0] == size_bit);
                    o_rf_rd_a   = REG_AX;
                    o_rf_wr_reg = REG_AX;
                    o_alu_op    = opcode[7] ? ALU_AND : opcode[5:3];
                    o_alu_size  = size_bit;
                    o_alu_a     = i_rf_a;
                    o_alu_b     = imm_word;
                    o_rf_we     = done && !opcode[7] && opcode[5:3] != ALU_CMP;
                    o_flags_we  = done;
                end
                8'b0100????: begin                    // INC, DEC r16
                    o_rf_rd_a   = opcode[2:0];
                    o_rf_wr_reg = opcode[2:0];
                    o_alu_op    = opcode[3] ? ALU_SUB : ALU_ADD;
                    o_alu_a     = i_rf_a;
                    o_alu_b     = 16'd1;
                    o_rf_we     = 1'b1;
                    o_flags_we  = 1'b1;
                    o_flags_new[FLAG_CF] = op_latch[0];   // CF sampled during fetch
                end
                8'b1011????: begin                    // MOV r,imm
                    done         = (step[0] == size_bit);
                    o_rf_wr_reg  = opcode[2:0];
                    o_rf_wr_data = imm_word;
                    o_rf_we      = done;
                end
                8'b101000??: begin                    // MOV acc <-> [addr]
                    done         = (step == 2'd3) || (step == 2'd2 && !size_bit);
                    o_rf_rd_a    = REG_AX;
                    o_rf_wr_reg  = REG_AX;
                    o_rf_wr_data = imm_word;
                    o_rf_we      = done && !dir_bit;
                end
                8'hE9:       done = step[0];
                8'b1111100?, 8'hF5: begin             // CLC, STC, CMC
                    o_carry_cmd_en = 1'b1;
                    if (opcode[3])
                        o_carry_cmd = opcode[0] ? CARRY_SET : CARRY_CLR;
                end
                default: ;                            // Jcc, JMP short
            endcase
        end
    end

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (i_rst) begin
            state <= ST_FETCH;
            ip    <= RESET_IP;
            step  <= '0;
            o_we  <= 1'b0;
        end else begin
            o_we <= 1'b0;
            case (state)
                ST_FETCH: begin
                    opcode   <= i_data;
                    size_bit <= i_data[0];
                    dir_bit  <= i_data[1];
                    op_latch <= i_alu_result;
                    ip       <= ip + 16'd1;
                    step     <= '0;
                    casez (i_data)
                        8'b00???0??, 8'b100001??, 8'b100010??: state <= ST_MODRM;
                        8'b00???10?, 8'b1010100?, 8'b101000??, 8'b0111????,
                        8'hEB, 8'hE9, 8'hF5, 8'b1111100?:      state <= ST_EXEC;
                        8'b0100????: begin
                            state    <= ST_EXEC;
                            size_bit <= 1'b1;
                        end
                        8'b1011????: begin
                            state    <= ST_EXEC;
                            size_bit <= i_data[3];
                        end
                        8'hF4:       state <= ST_HALT;
                        default:     state <= ST_FETCH;   // Unknown opcode is a no-op
                    endcase
                end
                ST_MODRM: begin
                    modrm <= i_data;
                    ip    <= ip + 16'd1;
                    state <= ST_EXEC;
                end
                ST_EXEC: begin
                    step <= step + 2'd1;
                    if (done)
                        state <= ST_FETCH;
                    casez (opcode)
                        8'b00???10?, 8'b1010100?, 8'b1011????: begin
                            ip       <= ip + 16'd1;
                            op_latch <= {8'h00, i_data};
                        end
                        8'hE9: begin
                            op_latch <= {8'h00, i_data};
                            ip       <= step[0] ? ip + 16'd1 + imm_word : ip + 16'd1;
                        end
                        8'b0111????, 8'hEB:
                            ip <= (opcode[7] || i_cond_true) ? ip + 16'd1 + disp : ip + 16'd1;
                        8'b1000011?:
                            if (!step[0]) op_latch <= i_rf_a;
                        8'b101000??: begin
                            case (step)
                                2'd0: begin
                                    ea_imm[7:0] <= i_data;
                                    ip          <= ip + 16'd1;
                                end
                                2'd1: begin
                                    ea_imm[15:8] <= i_data;
                                    ip           <= ip + 16'd1;
                                    o_we         <= dir_bit;     // Low byte next cycle
                                    o_data       <= i_rf_a[7:0];
                                end
                                default: begin
                                    ea_imm   <= ea_imm + 16'd1;
                                    op_latch <= {8'h00, i_data};
                                    o_we     <= dir_bit && size_bit && !step[0];
                                    o_data   <= i_rf_a[15:8];
                                end
                            endcase
                        end
                        default: ;
                    endcase
                end
                default: state <= ST_HALT;    // Held until reset
            endcase
        end
    end

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            clock,
    input  logic            i_rst,
    output cpu_pkg::addr_t  o_address,
    input  cpu_pkg::byte_t  i_data,     // Memory at o_address, same cycle
    output cpu_pkg::byte_t  o_data,
    output logic            o_we,
    output logic            o_halt
);
    import cpu_pkg::*;

    // Register file
    logic     rf_we, rf_size;
    reg_idx_t rf_wr_reg, rf_rd_a, rf_rd_b;
    word_t    rf_wr_data, rf_a, rf_b;

    // ALU
    alu_op_t  alu_op;
    logic     alu_size;
    word_t    alu_a, alu_b, alu_result;
    flags_t   alu_flags;

    // Flag unit
    logic       flags_we, carry_cmd_en, cond_true;
    logic [1:0] carry_cmd;
    logic [3:0] cond;
    flags_t     flags_new, flags;

    cpu_control u_control (
        .clock, .i_rst, .i_data, .o_address, .o_data, .o_we, .o_halt,
        .o_rf_we(rf_we), .o_rf_size(rf_size), .o_rf_wr_reg(rf_wr_reg),
        .o_rf_wr_data(rf_wr_data), .o_rf_rd_a(rf_rd_a), .o_rf_rd_b(rf_rd_b),
        .i_rf_a(rf_a), .i_rf_b(rf_b),
        .o_alu_op(alu_op), .o_alu_size(alu_size), .o_alu_a(alu_a), .o_alu_b(alu_b),
        .i_alu_result(alu_result), .i_alu_flags(alu_flags),
        .o_flags_we(flags_we), .o_flags_new(flags_new), .o_carry_cmd_en(carry_cmd_en),
        .o_carry_cmd(carry_cmd), .o_cond(cond), .i_cond_true(cond_true)
    );

    cpu_regfile u_regfile (
        .clock, .i_rst, .i_we(rf_we), .i_size(rf_size), .i_wr_reg(rf_wr_reg),
        .i_wr_data(rf_wr_data), .i_rd_a_reg(rf_rd_a), .o_rd_a(rf_a),
        .i_rd_b_reg(rf_rd_b), .o_rd_b(rf_b)
    );

    cpu_alu u_alu (
        .i_op(alu_op), .i_size(alu_size), .i_a(alu_a), .i_b(alu_b), .i_flags(flags),
        .o_result(alu_result), .o_flags(alu_flags)
    );

    cpu_flags u_flags (
        .clock, .i_rst, .i_we(flags_we), .i_new_flags(flags_new),
        .i_carry_cmd_en(carry_cmd_en), .i_carry_cmd(carry_cmd), .i_cond(cond),
        .o_flags(flags), .o_cond_true(cond_true)
    );

endmodule

//--- testbench/tb_cpu_assert.sv
`timescale 1ns/1ps

module tb_cpu_assert (
    input logic clock,
    input logic i_rst,
    input logic i_we,
    input logic i_halt
);
    int unsigned fails = 0;

    // Covers every reset cycle and the first one after it
    property we_quiet_after_reset;
        @(posedge clock) $past(i_rst) |-> !i_we;
    endproperty

    property no_store_in_halt;
        @(posedge clock) disable iff (i_rst) i_halt |-> !i_we;
    endproperty

    property halt_holds;
        @(posedge clock) disable iff (i_rst) i_halt |=> i_halt;
    endproperty

    we_reset_chk: assert property (we_quiet_after_reset) else begin
        fails++;
        $error("o_we high during or right after reset");
    end

    halt_we_chk: assert property (no_store_in_halt) else begin
        fails++;
        $error("o_we high while halted");
    end

    halt_hold_chk: assert property (halt_holds) else begin
        fails++;
        $error("o_halt dropped without reset");
    end

endmodule

bind cpu_top tb_cpu_assert u_assert (
    .clock(clock), .i_rst(i_rst), .i_we(o_we), .i_halt(o_halt)
);

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    logic   clock = 1'b0;
    logic   i_rst;
    addr_t  o_address;
    byte_t  i_data;
    byte_t  o_data;
    logic   o_we;
    logic   o_halt;

    byte_t  mem [65536];
    byte_t  ref_mem [65536];        // Model copy of memory
    addr_t  obs_addr [$];
    byte_t  obs_data [$];
    addr_t  exp_addr [$];
    byte_t  exp_data [$];

    word_t  m_reg [8];
    logic   m_cf, m_pf, m_zf, m_sf, m_of;
    addr_t  m_ip;
    addr_t  pc;                     // Program layout pointer
    int     n_instr;
    int     limit;
    int     errors = 0;

    cpu_top i_dut (
        .clock, .i_rst, .o_address, .i_data, .o_data, .o_we, .o_halt
    );

    always #2 clock = ~clock;

    assign i_data = mem[o_address];

    always @(posedge clock) begin
        if (o_we === 1'b1) begin
            mem[o_address] <= o_data;
            obs_addr.push_back(o_address);
            obs_data.push_back(o_data);
        end
    end

    // --------------------------------------------------
    // Program generator
    // --------------------------------------------------
    task automatic put_byte(input byte_t b);
        mem[pc] = b;
        pc = pc + 16'd1;
    endtask

    // Data addresses stay above the program
    function automatic addr_t rand_addr();
        return 16'h8000 + 16'($urandom_range(0, 32'h7ff0));
    endfunction

    task automatic store_acc(input logic w);
        addr_t a;
        a = rand_addr();
        put_byte({7'b1010001, w});      // A2 or A3
        put_byte(a[7:0]);
        put_byte(a[15:8]);
        n_instr++;
    endtask

    task automatic show_reg(input reg_idx_t r);
        put_byte(8'h8b);                // MOV AX,r16
        put_byte({5'b11000, r});
        store_acc(1'b1);
        n_instr++;
    endtask

    task automatic branch_over_store(input logic [3:0] cc);
        put_byte({4'h7, cc});
        put_byte(8'd3);                 // Length of one store
        store_acc(1'b1);
        store_acc(1'b1);
        n_instr++;
    endtask

    task automatic build_program(input int groups);
        logic [3:0] sel;
        logic [3:0] cc;
        reg_idx_t   r1, r2;
        logic       w, d;
        addr_t      a;
        int         skip;
        int         n_acc;
        pc      = RESET_IP;
        n_instr = 0;
        cc      = 4'd0;
        n_acc   = 0;
        for (int g = 0; g < groups; g++) begin
            r1 = 3'($urandom);
            r2 = 3'($urandom);
            w  = 1'($urandom);
            d  = 1'($urandom);
            case ($urandom_range(0, 6))
                0: begin
                    put_byte({4'b1011, w, r1});             // MOV r,imm
                    put_byte(8'($urandom));
                    if (w)
                        put_byte(8'($urandom));
                    put_byte({7'b1000101, w});              // MOV AL/AX,r
                    put_byte({5'b11000, r1});
                    store_acc(w);
                    n_instr += 2;
                end
                1: begin
                    sel = 4'($urandom_range(0, 3));
                    if (sel != 0) begin
                        put_byte(sel == 1 ? 8'hf8 : (sel == 2 ? 8'hf9 : 8'hf5));
                        n_instr++;
                    end
                    sel   = 4'(n_acc % 9);                  // Nine operations in both sizes
                    w     = 1'(n_acc / 9);
                    n_acc = n_acc + 1;
                    put_byte(sel == 8 ? {7'b1010100, w} : {2'b00, sel[2:0], 2'b10, w});
                    put_byte(8'($urandom));
                    if (w)
                        put_byte(8'($urandom));
                    store_acc(w);
                    n_instr++;
                end
                2: begin
                    sel = 4'($urandom_range(0, 10));
                    if (sel < 8)
                        put_byte({2'b00, sel[2:0], 1'b0, d, w});
                    else if (sel == 8)
                        put_byte({7'b1000010, w});          // TEST
                    else if (sel == 9)
                        put_byte({6'b100010, d, w});        // MOV
                    else
                        put_byte({7'b1000011, w});          // XCHG
                    put_byte({2'b11, r1, r2});
                    show_reg(w ? r1 : {1'b0, r1[1:0]});
                    show_reg(w ? r2 : {1'b0, r2[1:0]});
                    n_instr++;
                end
                3: begin
                    put_byte({4'b0100, d, r1});             // INC or DEC
                    show_reg(r1);
                    branch_over_store({3'b001, d});         // JB or JNB sees CF
                    n_instr++;
                end
                4: begin
                    branch_over_store(cc);                  // Condition codes in turn
                    cc = cc + 4'd1;
                end
                5: begin
                    a = rand_addr();
                    put_byte({7'b1010000, w});              // A0 or A1
                    put_byte(a[7:0]);
                    put_byte(a[15:8]);
                    store_acc(w);
                    n_instr++;
                end
                default: begin
                    skip = $urandom_range(0, 6);
                    put_byte(w ? 8'heb : 8'he9);
                    put_byte(8'(skip));
                    if (!w)
                        put_byte(8'h00);
                    repeat (skip)
                        put_byte(8'hf4);                    // HLT if the jump falls short
                    n_instr++;
                end
            endcase
        end
        put_byte(8'hf4);
        n_instr++;
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic byte_t next_byte();
        byte_t b;
        b    = ref_mem[m_ip];
        m_ip = m_ip + 16'd1;
        return b;
    endfunction

    function automatic word_t fetch_imm(input logic w);
        byte_t lo;
        byte_t hi;
        lo = next_byte();
        hi = 8'h00;
        if (w)
            hi = next_byte();
        return {hi, lo};
    endfunction

    function automatic word_t reg_value(input reg_idx_t idx, input logic w);
        if (w)
            return m_reg[idx];
        if (idx[2])
            return {8'h00, m_reg[idx[1:0]][15:8]};
        return {8'h00, m_reg[idx[1:0]][7:0]};
    endfunction

    function automatic void set_reg(input reg_idx_t idx, input logic w, input word_t val);
        if (w)
            m_reg[idx] = val;
        else if (idx[2])
            m_reg[idx[1:0]][15:8] = val[7:0];
        else
            m_reg[idx[1:0]][7:0] = val[7:0];
    endfunction

    function automatic void write_expected(input addr_t a, input byte_t b);
        ref_mem[a] = b;
        exp_addr.push_back(a);
        exp_data.push_back(b);
    endfunction

    function automatic void alu_model(input alu_op_t op, input logic w, input word_t a,
                                      input word_t b, output word_t res);
        int   msb, x, y, r;
        logic lg;
        msb = w ? 15 : 7;
        x   = w ? int'(a) : int'(a[7:0]);
        y   = w ? int'(b) : int'(b[7:0]);
        lg  = (op == ALU_OR || op == ALU_AND || op == ALU_XOR);
        case (op)
            ALU_ADD: r = x + y;
            ALU_OR:  r = x | y;
            ALU_ADC: r = x + y + int'(m_cf);
            ALU_SBB: r = x - y - int'(m_cf);
            ALU_AND: r = x & y;
            ALU_XOR: r = x ^ y;
            default: r = x - y;
        endcase
        res  = w ? word_t'(r) : {8'h00, byte_t'(r)};
        m_cf = !lg && (r < 0 || r > (w ? 65535 : 255));     // Carry or borrow out
        if (lg)
            m_of = 1'b0;
        else if (op == ALU_ADD || op == ALU_ADC)
            m_of = (a[msb] == b[msb]) && (res[msb] != a[msb]);
        else
            m_of = (a[msb] != b[msb]) && (res[msb] != a[msb]);
        m_zf = (res == 16'h0000);
        m_sf = res[msb];
        m_pf = ~^res[7:0];
    endfunction

    function automatic logic cond_holds(input logic [3:0] cc);
        logic t;
        case (cc[3:1])
            3'd0:    t = m_of;
            3'd1:    t = m_cf;
            3'd2:    t = m_zf;
            3'd3:    t = m_cf | m_zf;
            3'd4:    t = m_sf;
            3'd5:    t = m_pf;
            3'd6:    t = m_sf ^ m_of;
            default: t = (m_sf ^ m_of) | m_zf;
        endcase
        return t ^ cc[0];               // Odd codes negate
    endfunction

    function automatic void run_model();
        byte_t    op, mrm;
        word_t    a, b, res;
        addr_t    ea;
        reg_idx_t dst, src;
        logic     w, c, halted;
        int       count;
        m_ip   = RESET_IP;
        halted = 1'b0;
        count  = 0;
        for (int i = 0; i < 8; i++)
            m_reg[i] = '0;
        {m_cf, m_pf, m_zf, m_sf, m_of} = '0;
        while (!halted && count < 100000) begin
            op = next_byte();
            w  = op[0];
            count++;
            casez (op)
                8'b00???0??, 8'b100001??, 8'b100010??: begin
                    mrm = next_byte();
                    dst = op[1] ? mrm[5:3] : mrm[2:0];
                    src = op[1] ? mrm[2:0] : mrm[5:3];
                    a   = reg_value(dst, w);
                    b   = reg_value(src, w);
                    if (op[7:1] == 7'b1000011) begin
                        set_reg(dst, w, b);
                        set_reg(src, w, a);
                    end else if (op[7:2] == 6'b100010) begin
                        set_reg(dst, w, b);
                    end else begin
                        alu_model(op[7] ? ALU_AND : op[5:3], w, a, b, res);
                        if (!op[7] && op[5:3] != ALU_CMP)
                            set_reg(dst, w, res);
                    end
                end
                8'b00???10?, 8'b1010100?: begin
                    b = fetch_imm(w);
                    alu_model(op[7] ? ALU_AND : op[5:3], w, reg_value(REG_AX, w), b, res);
                    if (!op[7] && op[5:3] != ALU_CMP)
                        set_reg(REG_AX, w, res);
                end
                8'b0100????: begin
                    c = m_cf;           // CF survives INC and DEC
                    alu_model(op[3] ? ALU_SUB : ALU_ADD, 1'b1, m_reg[op[2:0]], 16'd1, res);
                    m_reg[op[2:0]] = res;
                    m_cf = c;
                end
                8'b1011????: set_reg(op[2:0], op[3], fetch_imm(op[3]));
                8'b101000??: begin
                    ea = fetch_imm(1'b1);
                    if (op[1]) begin
                        write_expected(ea, m_reg[REG_AX][7:0]);
                        if (w)
                            write_expected(ea + 16'd1, m_reg[REG_AX][15:8]);
                    end else begin
                        set_reg(REG_AX, w, {ref_mem[ea + 16'd1], ref_mem[ea]});
                    end
                end
                8'b0111????, 8'heb: begin
                    b = fetch_imm(1'b0);
                    if (op == 8'heb || cond_holds(op[3:0]))
                        m_ip = m_ip + {{8{b[7]}}, b[7:0]};
                end
                8'he9: begin
                    b    = fetch_imm(1'b1);
                    m_ip = m_ip + b;
                end
                8'hf8:   m_cf = 1'b0;
                8'hf9:   m_cf = 1'b1;
                8'hf5:   m_cf = !m_cf;
                8'hf4:   halted = 1'b1;
                default: ;
            endcase
        end
    endfunction

    // --------------------------------------------------
    // Stimulus, checker and watchdog
    // --------------------------------------------------
    initial begin
        void'($urandom(32'hd4ad7019));
        i_rst = 1'b1;
        for (int a = 0; a < 65536; a++)
            mem[a] = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5a;
        build_program(300);
        ref_mem = mem;
        run_model();
        limit = 40 * n_instr + 200;
        repeat (5) @(posedge clock);
        i_rst <= 1'b0;
    end

    initial begin : compare
        int n;
        @(negedge i_rst);
        while (o_halt !== 1'b1)
            @(posedge clock);
        repeat (4) @(posedge clock);    // Room for a stray store
        if (o_halt !== 1'b1) begin
            $display("o_halt fell after HLT without a reset");
            errors++;
        end
        if (obs_addr.size() != exp_addr.size()) begin
            $display("Store count differs: DUT made %0d stores, model expects %0d",
                     obs_addr.size(), exp_addr.size());
            errors++;
        end
        n = (obs_addr.size() < exp_addr.size()) ? obs_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            if (obs_addr[i] != exp_addr[i] || obs_data[i] != exp_data[i]) begin
                $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, i, obs_data[i], obs_addr[i], exp_data[i], exp_addr[i]);
                errors++;
            end
        end
        errors += i_dut.u_assert.fails;
        $display("%0d stores checked, %0d errors", n, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #1;
        repeat (limit) @(posedge clock);
        $display("Timeout: the CPU did not halt within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_regfile.sv
rtl/cpu_flags.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
testbench/tb_cpu_assert.sv
testbench/tb_cpu.sv
